/* rtl/axi_pkg.sv */
/*
 * AXI4 write-side types for the vector store path.
 * Address and data widths plus the AW and W channel payloads.
 */

`default_nettype none

package axi_pkg;

  localparam int unsigned AxiAddrWidth = 32;
  localparam int unsigned AxiDataWidth = 64;
  localparam int unsigned AxiStrbWidth = AxiDataWidth / 8;

  typedef logic [AxiAddrWidth-1:0] addr_t;
  typedef logic [AxiDataWidth-1:0] data_t;
  typedef logic [AxiStrbWidth-1:0] strb_t;
  typedef logic [7:0]              len_t;
  typedef logic [2:0]              size_t;
  typedef logic [1:0]              burst_t;

  // Incrementing burst encoding
  localparam burst_t BurstIncr = 2'b01;

  typedef struct packed {
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
  } axi_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } axi_w_t;

endpackage

`default_nettype wire

/* rtl/vlsu_pkg.sv */
/*
 * Vector side definitions of the store path: lane words, requests and the
 * per-beat transaction control record passed to the sequential store.
 */

`default_nettype none

package vlsu_pkg;

  import axi_pkg::*;

  localparam int unsigned NrLanesDefault = 4;
  localparam int unsigned LaneWidth      = 32;
  localparam int unsigned LaneBytes      = LaneWidth / 8;
  localparam int unsigned BusOffW        = $clog2(AxiStrbWidth);

  // Element width, also the log2 of the element size in bytes
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  typedef logic [LaneWidth-1:0] lane_word_t;
  typedef logic [LaneBytes-1:0] lane_be_t;
  typedef logic [15:0]          vl_t;
  typedef logic [7:0]           beat_cnt_t;
  typedef logic [BusOffW-1:0]   bus_off_t;
  typedef logic [BusOffW:0]     bus_cnt_t;

  typedef struct packed {
    lane_word_t data;
    lane_be_t   be;
  } lane_entry_t;

  typedef struct packed {
    addr_t addr;
    vl_t   vl;
    sew_e  sew;
  } store_req_t;

  // One record per W beat
  typedef struct packed {
    logic      isHead;
    logic      isFinal;
    beat_cnt_t rmn_beat;
    bus_off_t  head_off;
    bus_cnt_t  lb_end;
  } txn_ctrl_t;

endpackage

`default_nettype wire

/* rtl/lane_store_queue.sv */
/*
 * Two-entry store queue for one vector lane.
 * Decouples the lane's push timing from the joint pop in the deshuffle unit.
 */

`timescale 1ns/1ps
`default_nettype none

module lane_store_queue import vlsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  lane_entry_t in_i,

  output logic        out_valid_o,
  input  logic        out_ready_i,
  output lane_entry_t out_o
);

  lane_entry_t mem_q [2];

  // Bit 1 is the wrap flag, bit 0 the slot index
  logic [1:0] wr_ptr_q, rd_ptr_q;
  logic       push, pop;
  logic       empty, full;

  assign empty = (wr_ptr_q == rd_ptr_q);
  assign full  = (wr_ptr_q == (rd_ptr_q ^ 2'b10));

  assign in_ready_o  = !full;
  assign out_valid_o = !empty;
  assign out_o       = mem_q[rd_ptr_q[0]];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 2'd1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[0]] <= in_i;
    end
  end

endmodule

`default_nettype wire

/* rtl/deshuffle_unit.sv */
/*
 * Joins one word from every lane and rebuilds a sequential buffer entry
 * in memory byte order for the current element width.
 */

`timescale 1ns/1ps
`default_nettype none

module deshuffle_unit import vlsu_pkg::*; #(
  parameter int unsigned NrLanes = NrLanesDefault
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic        [NrLanes-1:0]         lane_valid_i,
  output logic        [NrLanes-1:0]         lane_ready_o,
  input  lane_entry_t [NrLanes-1:0]         lane_i,
  input  sew_e                              sew_i,

  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic [NrLanes*LaneBytes-1:0][7:0] out_data_o,
  output logic [NrLanes*LaneBytes-1:0]      out_be_o
);

  localparam int unsigned SeqBytes = NrLanes * LaneBytes;

  logic [SeqBytes-1:0][7:0] shuf_data;
  logic [SeqBytes-1:0]      shuf_be;
  logic                     out_valid_q;
  logic                     fire;

  // All lanes must present a word and the output register must be free
  assign fire         = (&lane_valid_i) && (!out_valid_q || out_ready_i);
  assign lane_ready_o = {NrLanes{fire}};
  assign out_valid_o  = out_valid_q;

  // Byte j of lane l belongs to slot j/sew_bytes, byte j%sew_bytes of that element
  always_comb begin
    int unsigned dst;
    shuf_data = '0;
    shuf_be   = '0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      for (int unsigned j = 0; j < LaneBytes; j++) begin
        case (sew_i)
          SEW8:    dst = j * NrLanes + l;
          SEW16:   dst = ((j / 2) * NrLanes + l) * 2 + (j % 2);
          default: dst = l * 4 + j;
        endcase
        shuf_data[dst] = lane_i[l].data[8*j +: 8];
        shuf_be[dst]   = lane_i[l].be[j];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      out_valid_q <= 1'b0;
    end else if (fire) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      out_data_o <= shuf_data;
      out_be_o   <= shuf_be;
    end
  end

endmodule

`default_nettype wire

/* rtl/store_txn_gen.sv */
/*
 * Turns a unit-stride store request into one AW burst and a stream of
 * per-beat transaction control records. Holds the request SEW meanwhile.
 */

`timescale 1ns/1ps
`default_nettype none

module store_txn_gen import vlsu_pkg::*; import axi_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       req_valid_i,
  output logic       req_ready_o,
  input  store_req_t req_i,

  output logic       aw_valid_o,
  input  logic       aw_ready_i,
  output axi_aw_t    aw_o,

  output logic       txn_valid_o,
  input  logic       txn_ready_i,
  output txn_ctrl_t  txn_o,
  output sew_e       sew_o
);

  typedef enum logic [1:0] {
    IDLE,
    ADDR,
    BEATS
  } state_e;

  state_e    state_q;
  beat_cnt_t rmn_q;
  logic      txn_done_q;
  sew_e      sew_q;

  // Request geometry, captured on acceptance
  addr_t     base_q;
  len_t      len_q;
  bus_off_t  head_q;
  bus_cnt_t  lb_end_q;

  logic [17:0] req_bytes;
  logic [18:0] req_span;
  logic [18:0] req_beats;
  bus_cnt_t    req_lb_end;
  logic        req_fire, txn_fire, final_fire;

  // ==================================================
  // Burst geometry
  // ==================================================
  assign req_bytes  = 18'(req_i.vl) << req_i.sew;
  assign req_span   = 19'(req_i.addr[BusOffW-1:0]) + 19'(req_bytes);
  assign req_beats  = (req_span + 19'(AxiStrbWidth - 1)) >> BusOffW;
  assign req_lb_end = (req_span[BusOffW-1:0] == '0) ? bus_cnt_t'(AxiStrbWidth)
                                                    : bus_cnt_t'(req_span[BusOffW-1:0]);

  assign req_ready_o = (state_q == IDLE);
  assign aw_valid_o  = (state_q == ADDR);
  assign txn_valid_o = (state_q != IDLE) && !txn_done_q;
  assign sew_o       = sew_q;

  assign req_fire   = req_valid_i && req_ready_o;
  assign txn_fire   = txn_valid_o && txn_ready_i;
  assign final_fire = txn_fire && (rmn_q == '0);

  assign aw_o.addr  = base_q;
  assign aw_o.len   = len_q;
  assign aw_o.size  = size_t'(BusOffW);
  assign aw_o.burst = BurstIncr;

  assign txn_o.isHead   = (rmn_q == len_q);
  assign txn_o.isFinal  = (rmn_q == '0);
  assign txn_o.rmn_beat = rmn_q;
  assign txn_o.head_off = head_q;
  assign txn_o.lb_end   = lb_end_q;

  // ==================================================
  // Control FSM and beat counter
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      rmn_q      <= '0;
      txn_done_q <= 1'b0;
      sew_q      <= SEW8;
    end else begin
      if (txn_fire && rmn_q != '0) begin
        rmn_q <= rmn_q - 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (req_fire) begin
            state_q    <= ADDR;
            rmn_q      <= beat_cnt_t'(req_beats - 19'd1);
            txn_done_q <= 1'b0;
            sew_q      <= req_i.sew;
          end
        end
        ADDR: begin
          // Beats may run ahead of the AW handshake
          if (aw_ready_i) begin
            state_q <= (txn_done_q || final_fire) ? IDLE : BEATS;
          end else if (final_fire) begin
            txn_done_q <= 1'b1;
          end
        end
        BEATS: begin
          if (final_fire) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      base_q   <= {req_i.addr[AxiAddrWidth-1:BusOffW], {BusOffW{1'b0}}};
      len_q    <= len_t'(req_beats - 19'd1);
      head_q   <= req_i.addr[BusOffW-1:0];
      lb_end_q <= req_lb_end;
    end
  end

endmodule

`default_nettype wire

/* rtl/sequential_store.sv */
/*
 * Packs sequential buffer bytes into aligned AXI W beats.
 * A ping-pong sequential buffer feeds a two-deep W buffer, one beat per
 * transaction control record. Strobes follow the element byte enables.
 */

`timescale 1ns/1ps
`default_nettype none

module sequential_store import vlsu_pkg::*; import axi_pkg::*; #(
  parameter int unsigned NrLanes = NrLanesDefault
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,

  input  logic                              rx_valid_i,
  output logic                              rx_ready_o,
  input  logic [NrLanes*LaneBytes-1:0][7:0] rx_data_i,
  input  logic [NrLanes*LaneBytes-1:0]      rx_be_i,

  input  logic                              txn_valid_i,
  output logic                              txn_ready_o,
  input  txn_ctrl_t                         txn_i,

  output logic                              w_valid_o,
  input  logic                              w_ready_i,
  output axi_w_t                            w_o
);

  localparam int unsigned SeqBytes = NrLanes * LaneBytes;
  localparam int unsigned SeqPtrW  = $clog2(SeqBytes);
  localparam int unsigned CntW     = SeqPtrW + 2;

  typedef struct packed {
    logic [SeqBytes-1:0][7:0] data;
    logic [SeqBytes-1:0]      be;
  } seq_buf_t;

  typedef enum logic {
    IDLE,
    SERIAL
  } state_e;

  typedef logic [CntW-1:0] cnt_t;

  // ==================================================
  // Storage and pointers
  // ==================================================
  seq_buf_t seq_buf_q [2];
  axi_w_t   w_buf_q   [2];

  // Bit 1 of each pointer is its wrap flag
  logic [1:0] seq_wr_q, seq_rd_q, w_wr_q, w_rd_q;
  logic       seq_empty, seq_full, seq_enq, seq_deq;
  logic       w_empty, w_full, w_enq, w_deq;

  state_e               state_q, state_d;
  bus_off_t             bus_cnt_q, bus_cnt_d, bus_cnt;
  logic [SeqPtrW-1:0]   seq_ptr_q, seq_ptr_d, seq_ptr;

  // Partially filled beat waiting for the next buffer entry
  logic [AxiStrbWidth-1:0][7:0] pend_data_q, beat_data;
  strb_t                        pend_strb_q, beat_strb;

  logic commit, final_beat;
  cnt_t lower, upper, bus_valid, seq_valid, n_commit, start, stop;

  assign seq_empty = (seq_wr_q == seq_rd_q);
  assign seq_full  = (seq_wr_q == (seq_rd_q ^ 2'b10));
  assign w_empty   = (w_wr_q == w_rd_q);
  assign w_full    = (w_wr_q == (w_rd_q ^ 2'b10));

  assign rx_ready_o = !seq_full;
  assign seq_enq    = rx_valid_i && rx_ready_o;

  assign w_valid_o = !w_empty;
  assign w_o       = w_buf_q[w_rd_q[0]];
  assign w_deq     = w_valid_o && w_ready_i;

  // A new request always starts at byte 0 of the buffer and the beat
  assign bus_cnt    = (state_q == IDLE) ? '0 : bus_cnt_q;
  assign seq_ptr    = (state_q == IDLE) ? '0 : seq_ptr_q;
  assign final_beat = txn_i.isFinal;

  // ==================================================
  // Commit from sequential buffer to W buffer
  // ==================================================
  always_comb begin
    state_d     = state_q;
    bus_cnt_d   = bus_cnt;
    seq_ptr_d   = seq_ptr;
    txn_ready_o = 1'b0;
    seq_deq     = 1'b0;
    w_enq       = 1'b0;
    commit      = 1'b0;

    // Valid byte window of this beat
    lower     = txn_i.isHead ? cnt_t'(txn_i.head_off) : '0;
    upper     = (txn_i.rmn_beat == '0) ? cnt_t'(txn_i.lb_end) : cnt_t'(AxiStrbWidth);
    bus_valid = upper - lower - cnt_t'(bus_cnt);
    seq_valid = cnt_t'(SeqBytes) - cnt_t'(seq_ptr);
    n_commit  = (bus_valid > seq_valid) ? seq_valid : bus_valid;
    start     = lower + cnt_t'(bus_cnt);
    stop      = start + n_commit;

    if (txn_valid_i) begin
      state_d = SERIAL;
    end

    if (txn_valid_i && !seq_empty && !w_full) begin
      commit = 1'b1;
      if (bus_valid > seq_valid) begin
        // Entry runs out before the beat is complete
        bus_cnt_d = bus_cnt + bus_off_t'(n_commit);
        seq_ptr_d = '0;
        seq_deq   = 1'b1;
      end else begin
        bus_cnt_d   = '0;
        seq_ptr_d   = seq_ptr + SeqPtrW'(n_commit);
        txn_ready_o = 1'b1;
        w_enq       = 1'b1;
        // Padding left in the entry after the final beat is dropped
        if (bus_valid == seq_valid || final_beat) begin
          seq_deq   = 1'b1;
          seq_ptr_d = '0;
        end
        if (final_beat) begin
          state_d = IDLE;
        end
      end
    end
  end

  // Overlay the committed bytes on the pending beat
  always_comb begin
    logic [SeqPtrW-1:0] src;
    beat_data = pend_data_q;
    beat_strb = pend_strb_q;
    for (int unsigned i = 0; i < AxiStrbWidth; i++) begin
      src = SeqPtrW'(cnt_t'(i) - start + cnt_t'(seq_ptr));
      if (cnt_t'(i) >= start && cnt_t'(i) < stop) begin
        beat_data[i] = seq_buf_q[seq_rd_q[0]].data[src];
        beat_strb[i] = seq_buf_q[seq_rd_q[0]].be[src];
      end
    end
  end

  // ==================================================
  // Registers
  // ==================================================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      bus_cnt_q   <= '0;
      seq_ptr_q   <= '0;
      seq_wr_q    <= '0;
      seq_rd_q    <= '0;
      w_wr_q      <= '0;
      w_rd_q      <= '0;
      pend_strb_q <= '0;
    end else begin
      state_q   <= state_d;
      bus_cnt_q <= bus_cnt_d;
      seq_ptr_q <= seq_ptr_d;
      if (seq_enq) seq_wr_q <= seq_wr_q + 2'd1;
      if (seq_deq) seq_rd_q <= seq_rd_q + 2'd1;
      if (w_enq)   w_wr_q   <= w_wr_q + 2'd1;
      if (w_deq)   w_rd_q   <= w_rd_q + 2'd1;
      if (commit) begin
        pend_strb_q <= w_enq ? '0 : beat_strb;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (seq_enq) begin
      seq_buf_q[seq_wr_q[0]] <= '{data: rx_data_i, be: rx_be_i};
    end
    if (commit && !w_enq) begin
      pend_data_q <= beat_data;
    end
    if (w_enq) begin
      w_buf_q[w_wr_q[0]] <= '{data: beat_data, strb: beat_strb,
                              last: (txn_i.rmn_beat == '0)};
    end
  end

endmodule

`default_nettype wire

/* rtl/vector_store_top.sv */
/*
 * Store data path of the vector load-store unit.
 * Lane queues feed the deshuffle unit; the sequential store packs the
 * result into AXI W beats under control of the transaction generator.
 */

`timescale 1ns/1ps
`default_nettype none

module vector_store_top import vlsu_pkg::*; import axi_pkg::*; #(
  parameter int unsigned NrLanes = NrLanesDefault
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,

  input  logic        [NrLanes-1:0] lane_valid_i,
  output logic        [NrLanes-1:0] lane_ready_o,
  input  lane_entry_t [NrLanes-1:0] lane_data_i,

  input  logic                      req_valid_i,
  output logic                      req_ready_o,
  input  store_req_t                req_i,

  output logic                      aw_valid_o,
  input  logic                      aw_ready_i,
  output axi_aw_t                   aw_o,

  output logic                      w_valid_o,
  input  logic                      w_ready_i,
  output axi_w_t                    w_o
);

  localparam int unsigned SeqBytes = NrLanes * LaneBytes;

  logic        [NrLanes-1:0] q_valid, q_ready;
  lane_entry_t [NrLanes-1:0] q_data;

  logic                     rx_valid, rx_ready;
  logic [SeqBytes-1:0][7:0] rx_data;
  logic [SeqBytes-1:0]      rx_be;

  logic      txn_valid, txn_ready;
  txn_ctrl_t txn;
  sew_e      sew;

  // ==================================================
  // Per-lane store queues
  // ==================================================
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane_q
    lane_store_queue i_lane_q (
      .clk_i      (clk_i          ),
      .rst_ni     (rst_ni         ),
      .in_valid_i (lane_valid_i[l]),
      .in_ready_o (lane_ready_o[l]),
      .in_i       (lane_data_i[l] ),
      .out_valid_o(q_valid[l]     ),
      .out_ready_i(q_ready[l]     ),
      .out_o      (q_data[l]      )
    );
  end

  deshuffle_unit #(.NrLanes(NrLanes)) i_deshuffle (
    .clk_i       (clk_i   ),
    .rst_ni      (rst_ni  ),
    .lane_valid_i(q_valid ),
    .lane_ready_o(q_ready ),
    .lane_i      (q_data  ),
    .sew_i       (sew     ),
    .out_valid_o (rx_valid),
    .out_ready_i (rx_ready),
    .out_data_o  (rx_data ),
    .out_be_o    (rx_be   )
  );

  store_txn_gen i_txn_gen (
    .clk_i      (clk_i      ),
    .rst_ni     (rst_ni     ),
    .req_valid_i(req_valid_i),
    .req_ready_o(req_ready_o),
    .req_i      (req_i      ),
    .aw_valid_o (aw_valid_o ),
    .aw_ready_i (aw_ready_i ),
    .aw_o       (aw_o       ),
    .txn_valid_o(txn_valid  ),
    .txn_ready_i(txn_ready  ),
    .txn_o      (txn        ),
    .sew_o      (sew        )
  );

  sequential_store #(.NrLanes(NrLanes)) i_seq_store (
    .clk_i      (clk_i    ),
    .rst_ni     (rst_ni   ),
    .rx_valid_i (rx_valid ),
    .rx_ready_o (rx_ready ),
    .rx_data_i  (rx_data  ),
    .rx_be_i    (rx_be    ),
    .txn_valid_i(txn_valid),
    .txn_ready_o(txn_ready),
    .txn_i      (txn      ),
    .w_valid_o  (w_valid_o),
    .w_ready_i  (w_ready_i),
    .w_o        (w_o      )
  );

endmodule

`default_nettype wire

/* testbench/vector_store_checker.sv */
/*
 * Protocol checks for the AXI write side of the vector store path.
 * Bound into vector_store_top, it reports through failing assertions.
 */

`timescale 1ns/1ps
`default_nettype none

module vector_store_checker import axi_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input logic    aw_valid_i,
  input logic    aw_ready_i,
  input axi_aw_t aw_i,
  input logic    w_valid_i,
  input logic    w_ready_i,
  input axi_w_t  w_i
);

  logic       aw_fire, w_last_fire;
  logic [3:0] aw_pend_q;

  assign aw_fire     = aw_valid_i && aw_ready_i;
  assign w_last_fire = w_valid_i && w_ready_i && w_i.last;

  // Bursts whose address is accepted but whose last beat is not yet out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      aw_pend_q <= '0;
    end else begin
      aw_pend_q <= aw_pend_q + 4'(aw_fire) - 4'(w_last_fire);
    end
  end

  aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
    else $error("AW valid dropped or payload changed while stalled");

  w_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i && !w_ready_i |=> w_valid_i && $stable(w_i))
    else $error("W valid dropped or payload changed while stalled");

  w_after_aw: assert property (@(posedge clk_i) disable iff (!rst_ni)
    w_valid_i |-> aw_pend_q != '0)
    else $error("W beat presented before the AW of its burst");

endmodule

bind vector_store_top vector_store_checker i_checker (
  .clk_i     (clk_i     ),
  .rst_ni    (rst_ni    ),
  .aw_valid_i(aw_valid_o),
  .aw_ready_i(aw_ready_i),
  .aw_i      (aw_o      ),
  .w_valid_i (w_valid_o ),
  .w_ready_i (w_ready_i ),
  .w_i       (w_o       )
);

`default_nettype wire

/* testbench/tb_vector_store.sv */
/*
 * Testbench for the vector store data path. Reads the case table, drives
 * request and lanes, models an AXI slave memory and checks every burst.
 */

`timescale 1ns/1ps
`default_nettype none

module tb_vector_store import vlsu_pkg::*, axi_pkg::*; ();

  localparam int unsigned NrLanes   = 4;
  localparam int unsigned MaxCases  = 32;
  localparam int unsigned MaxVl     = 512;
  localparam int unsigned MemBytes  = 4096;
  localparam int unsigned ClkPeriod = 100;

  logic                      clk_i, rst_ni;
  logic        [NrLanes-1:0] lane_valid_i, lane_ready_o;
  lane_entry_t [NrLanes-1:0] lane_data_i;
  logic                      req_valid_i, req_ready_o;
  store_req_t                req_i;
  logic                      aw_valid_o, aw_ready_i;
  axi_aw_t                   aw_o;
  logic                      w_valid_o, w_ready_i;
  axi_w_t                    w_o;

  // ==================================================
  // Case table, element data and memories
  // ==================================================
  string       case_name  [MaxCases];
  sew_e        case_sew   [MaxCases];
  int          case_vl    [MaxCases];
  int          case_base  [MaxCases];
  int          case_stall [MaxCases];
  logic [31:0] elem_val   [MaxCases][MaxVl];
  logic        elem_en    [MaxCases][MaxVl];
  logic [7:0]  mem        [MemBytes];
  logic [7:0]  exp_mem    [MemBytes];
  axi_aw_t     aw_q       [$];

  int          n_cases, done_cnt, case_errs, fail_tests, total_errs, seed;
  longint      limit_cycles;
  logic        cases_loaded;

  vector_store_top #(.NrLanes(NrLanes)) UUT (
    .clk_i       (clk_i       ),
    .rst_ni      (rst_ni      ),
    .lane_valid_i(lane_valid_i),
    .lane_ready_o(lane_ready_o),
    .lane_data_i (lane_data_i ),
    .req_valid_i (req_valid_i ),
    .req_ready_o (req_ready_o ),
    .req_i       (req_i       ),
    .aw_valid_o  (aw_valid_o  ),
    .aw_ready_i  (aw_ready_i  ),
    .aw_o        (aw_o        ),
    .w_valid_o   (w_valid_o   ),
    .w_ready_i   (w_ready_i   ),
    .w_o         (w_o         )
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  function automatic logic [7:0] fill_byte(input int a);
    return 8'((a * 7) ^ (a >> 8) ^ 'h5a);
  endfunction

  function automatic int sew_bytes(input int c);
    return 1 << case_sew[c];
  endfunction

  function automatic int beats_of(input int c);
    return (case_base[c] % 8 + case_vl[c] * sew_bytes(c) + 7) / 8;
  endfunction

  // Byte is written only inside the store region and for enabled elements
  function automatic logic strb_of(input int c, input int a);
    int off;
    off = a - case_base[c];
    if (off < 0 || off >= case_vl[c] * sew_bytes(c)) begin
      return 1'b0;
    end
    return elem_en[c][off / sew_bytes(c)];
  endfunction

  // Element e sits in lane e mod NrLanes at slot e div NrLanes
  function automatic lane_entry_t lane_word(input int c, input int l, input int w);
    lane_entry_t ent;
    int          sb, e;
    sb  = sew_bytes(c);
    ent = '0;
    for (int j = 0; j < 4; j++) begin
      e = (w * (4 / sb) + j / sb) * NrLanes + l;
      if (e < case_vl[c]) begin
        ent.data[8*j +: 8] = elem_val[c][e][8*(j % sb) +: 8];
        ent.be[j]          = elem_en[c][e];
      end
    end
    return ent;
  endfunction

  task automatic load_cases();
    int    fd, n, sew_bits, mask, sb;
    string tok, rest;
    fd = $fopen("testbench/store_cases.txt", "r");
    if (fd != 0) begin
      while ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.getc(0) == "#") begin
          void'($fgets(rest, fd));
        end else begin
          n = $fscanf(fd, "%d %d %h %d %d", sew_bits, case_vl[n_cases],
                      case_base[n_cases], mask, case_stall[n_cases]);
          if (n != 5 || n_cases >= MaxCases || case_vl[n_cases] > MaxVl) begin
            $display("Malformed or oversized case line starting with %s", tok);
            total_errs++;
          end else begin
            case_name[n_cases] = tok;
            case_sew[n_cases]  = (sew_bits == 8) ? SEW8 : (sew_bits == 16) ? SEW16 : SEW32;
            sb = sew_bytes(n_cases);
            for (int e = 0; e < case_vl[n_cases]; e++) begin
              elem_val[n_cases][e] = $random(seed);
              case (mask)
                0:       elem_en[n_cases][e] = 1'b1;
                1:       elem_en[n_cases][e] = (e % 2 == 0);
                default: elem_en[n_cases][e] = 1'($random(seed));
              endcase
              for (int b = 0; b < sb; b++) begin
                if (elem_en[n_cases][e]) begin
                  exp_mem[case_base[n_cases] + e * sb + b] = elem_val[n_cases][e][8*b +: 8];
                end
              end
            end
            limit_cycles += case_vl[n_cases] * 4;
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic send_req(input int c);
    req_i.addr  = addr_t'(case_base[c]);
    req_i.vl    = vl_t'(case_vl[c]);
    req_i.sew   = case_sew[c];
    req_valid_i = 1'b1;
    @(posedge clk_i);
    while (!req_ready_o) begin
      @(posedge clk_i);
    end
    #1;
    req_valid_i = 1'b0;
  endtask

  task automatic push_lanes(input int c);
    int   nw;
    int   idx [NrLanes];
    logic busy;
    nw   = (case_vl[c] * sew_bytes(c) + NrLanes * 4 - 1) / (NrLanes * 4);
    busy = 1'b1;
    for (int l = 0; l < NrLanes; l++) begin
      idx[l] = 0;
    end
    while (busy) begin
      busy = 1'b0;
      for (int l = 0; l < NrLanes; l++) begin
        lane_valid_i[l] = (idx[l] < nw);
        if (idx[l] < nw) begin
          lane_data_i[l] = lane_word(c, l, idx[l]);
          busy = 1'b1;
        end
      end
      if (busy) begin
        @(posedge clk_i);
        for (int l = 0; l < NrLanes; l++) begin
          if (lane_valid_i[l] && lane_ready_o[l]) begin
            idx[l]++;
          end
        end
        #1;
      end
    end
  endtask

  task automatic check_aw(input axi_aw_t aw);
    int c;
    c = done_cnt;
    if (aw.addr !== addr_t'(case_base[c] & ~7)) begin
      $display("** Error: %s: AW addr expected %h actual %h", case_name[c],
               case_base[c] & ~7, aw.addr);
      case_errs++;
    end
    if (int'(aw.len) + 1 != beats_of(c) || aw.size !== 3'd3) begin
      $display("** Error: %s: AW beats/size expected %0d/3 actual %0d/%0d", case_name[c],
               beats_of(c), int'(aw.len) + 1, aw.size);
      case_errs++;
    end
    if (aw.burst !== 2'b01) begin
      $display("** Error: %s: AW burst expected 01 actual %b", case_name[c], aw.burst);
      case_errs++;
    end
  endtask

  task automatic take_beat(input axi_aw_t aw, input int beat);
    int    c;
    strb_t exp_strb;
    logic  exp_last;
    c        = done_cnt;
    exp_last = (beat == beats_of(c) - 1);
    for (int i = 0; i < 8; i++) begin
      exp_strb[i] = strb_of(c, (case_base[c] & ~7) + beat * 8 + i);
    end
    if (w_o.strb !== exp_strb) begin
      $display("** Error: %s: strobe of beat %0d expected %h actual %h", case_name[c],
               beat, exp_strb, w_o.strb);
      case_errs++;
    end
    if (w_o.last !== exp_last) begin
      $display("** Error: %s: last of beat %0d expected %b actual %b", case_name[c],
               beat, exp_last, w_o.last);
      case_errs++;
    end
    for (int i = 0; i < 8; i++) begin
      if (w_o.strb[i]) begin
        mem[(int'(aw.addr) + beat * 8 + i) % MemBytes] = w_o.data[8*i +: 8];
      end
    end
  endtask

  // Region plus one bus word on either side must match the expected image
  task automatic finish_case();
    int c, lo, hi;
    c  = done_cnt;
    lo = (case_base[c] >= 8) ? case_base[c] - 8 : 0;
    hi = case_base[c] + case_vl[c] * sew_bytes(c) + 8;
    for (int a = lo; a < hi && a < MemBytes; a++) begin
      if (mem[a] !== exp_mem[a]) begin
        $display("** Error: %s: byte %h expected %h actual %h", case_name[c], a,
                 exp_mem[a], mem[a]);
        case_errs++;
      end
    end
    if (case_errs == 0) begin
      $display("Test %-18s pass", case_name[c]);
    end else begin
      $display("Test %-18s fail, %0d errors", case_name[c], case_errs);
      fail_tests++;
    end
    total_errs += case_errs;
    case_errs   = 0;
    done_cnt++;
  endtask

  // ==================================================
  // AXI slave memory model with W ready stalls
  // ==================================================
  // AW is accepted one cycle after it is first presented
  initial begin : axi_slave
    int      beat;
    axi_aw_t cur_aw;
    logic    aw_seen;
    beat    = 0;
    cur_aw  = '0;
    aw_seen = 1'b0;
    forever begin
      @(posedge clk_i);
      if (aw_valid_o && aw_ready_i) begin
        aw_q.push_back(aw_o);
      end
      aw_seen = aw_valid_o && !aw_ready_i;
      if (w_valid_o && w_ready_i && done_cnt >= n_cases) begin
        $display("W beat arrived after the last test had completed");
        total_errs++;
      end else if (w_valid_o && w_ready_i) begin
        if (beat == 0 && aw_q.size() == 0) begin
          $display("W beat of test %s arrived before its AW", case_name[done_cnt]);
          case_errs++;
        end else if (beat == 0) begin
          cur_aw = aw_q.pop_front();
          check_aw(cur_aw);
        end
        take_beat(cur_aw, beat);
        beat++;
        if (w_o.last) begin
          finish_case();
          beat = 0;
        end
      end
      #1;
      aw_ready_i = aw_seen;
      if (done_cnt < n_cases && case_stall[done_cnt] > 0) begin
        w_ready_i = ($unsigned($random(seed)) % 100) >= case_stall[done_cnt];
      end else begin
        w_ready_i = 1'b1;
      end
    end
  end

  initial begin : watchdog
    wait (cases_loaded);
    #(limit_cycles * ClkPeriod);
    $display("Timeout after %0d cycles with %0d of %0d tests done", limit_cycles,
             done_cnt, n_cases);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    lane_valid_i = '0;
    lane_data_i  = '0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    aw_ready_i   = 1'b0;
    w_ready_i    = 1'b1;
    seed         = 17;
    n_cases      = 0;
    done_cnt     = 0;
    case_errs    = 0;
    fail_tests   = 0;
    total_errs   = 0;
    limit_cycles = 50;
    cases_loaded = 1'b0;
    for (int a = 0; a < MemBytes; a++) begin
      mem[a]     = fill_byte(a);
      exp_mem[a] = fill_byte(a);
    end
    load_cases();
    if (n_cases == 0) begin
      $display("No test case could be read from testbench/store_cases.txt");
      $display("*** FAILED ***");
    end else begin
      cases_loaded = 1'b1;
      repeat (10) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;
      // Requests go out back to back, each followed by its lane data
      for (int c = 0; c < n_cases; c++) begin
        send_req(c);
        push_lanes(c);
      end
      wait (done_cnt == n_cases);
      repeat (2) @(posedge clk_i);
      for (int a = 0; a < MemBytes; a++) begin
        if (mem[a] !== exp_mem[a]) begin
          $display("** Error: memory_image: byte %h expected %h actual %h", a,
                   exp_mem[a], mem[a]);
          total_errs++;
        end
      end
      $display("Tests: %0d run, %0d passed, %0d failed, %0d errors", n_cases,
               n_cases - fail_tests, fail_tests, total_errs);
      if (fail_tests == 0 && total_errs == 0) begin
        $display("*** PASSED ***");
      end else begin
        $display("*** FAILED ***");
      end
    end
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/store_cases.txt */
# name  sew(bits)  vl  base(hex)  mask(0 all, 1 even only, 2 random)  w_ready stall(%)
sew8_aligned        8   32  000  0  0
sew16_aligned      16   24  100  0  0
sew32_aligned      32   16  200  0  0
sew8_unaligned      8   37  303  0  0
sew16_head         16   13  402  0  0
sew32_tail         32    7  504  0  0
sew8_single         8    3  605  0  0
sew16_masked       16   20  700  1  0
sew32_random_mask  32   19  80c  2  0
sew8_stall          8   37  903  0  40
sew32_stall        32   19  a0c  2  60
sew16_long         16  300  b00  2  25

/* flist.f */
rtl/axi_pkg.sv
rtl/vlsu_pkg.sv
rtl/lane_store_queue.sv
rtl/deshuffle_unit.sv
rtl/store_txn_gen.sv
rtl/sequential_store.sv
rtl/vector_store_top.sv
testbench/vector_store_checker.sv
testbench/tb_vector_store.sv
